//--- filelist.f
+incdir+.
zports_pkg.sv
io_strobe.sv
port_decode.sv
paging_regs.sv
ula_sd_regs.sv
read_mux.sv
zports.sv
tb_zports.sv

//--- io_strobe.sv
/* an access must stay low for at least two zclk edges
   one strobe per access, whatever its length */
`timescale 1ns/1ps

module io_strobe
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic wr_now;  // io write on the bus now
	logic rd_now;  // io read on the bus now
	logic wr_prev; // as sampled at the last edge
	logic rd_prev;

	assign wr_now = ~(iorq_n | wr_n);
	assign rd_now = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_prev <= 1'b0;
			rd_prev <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			wr_prev <= wr_now;
			rd_prev <= rd_now;
			port_wr <= wr_now & ~wr_prev; // leading edge only
			port_rd <= rd_now & ~rd_prev;
		end
	end

endmodule

//--- paging_regs.sv
/* rst_rom is sampled into the #7FFD rom bit during reset and must be stable then
   #7FFD writes are locked while bit 5 and the #EFF7 1M block bit are both set */
`timescale 1ns/1ps
`include "zports_params.svh"

module paging_regs
	import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  zbyte_t     din,
	input  logic       p7ffd_wr,
	input  logic       eff7_wr,
	input  logic       bf_wr,
	input  logic       dos,
	input  logic       rst_rom,
	output logic       shadow,
	output logic       romrw_en,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0,
	output zbyte_t     p7ffd,
	output zbyte_t     peff7,
	output logic [5:0] pent1m_page
);

	zbyte_t p7ffd_q; // 2:0 page, 3 screen, 4 rom, 5 lock, 7:6 high page
	zbyte_t peff7_q; // 2 block1m, 3 ram0 at 0
	logic   shadow_en_q; // #BF bit 0
	logic   romrw_en_q;  // #BF bit 1
	logic   block1m;
	logic   lock7ffd;

	assign block1m  = peff7_q[2];
	assign lock7ffd = p7ffd_q[5] & block1m;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q     <= (`ZP_P7FFD_RST & 8'hEF) | {3'b000, rst_rom, 4'b0000};
			peff7_q     <= `ZP_PEFF7_RST;
			shadow_en_q <= 1'b0;
			romrw_en_q  <= 1'b0;
		end
		else
		begin
			if (p7ffd_wr && !lock7ffd)
				p7ffd_q <= din;
			if (eff7_wr)
				peff7_q <= din;
			if (bf_wr)
			begin
				shadow_en_q <= din[0];
				romrw_en_q  <= din[1];
			end
		end
	end

	//////////////////////
	// outputs
	assign shadow   = dos | shadow_en_q; // dos rom or forced
	assign romrw_en = romrw_en_q;

	// high page bits hidden in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]}; // 1 MB page number
	assign pent1m_1m_on  = ~peff7_q[2];
	assign pent1m_ram0_0 = peff7_q[3];

endmodule

//--- port_decode.sv
/* purely combinational, all address and shadow decode lives here
   #7FFD block rule is applied later in the paging registers */
`timescale 1ns/1ps
`include "zports_params.svh"

module port_decode
	import zports_pkg::*;
(
	input  zaddr_t  a,
	input  logic    port_wr,
	input  logic    port_rd,
	input  logic    iorq_n,
	input  logic    rd_n,
	input  logic    shadow,
	output logic    porthit,
	output logic    dataout,
	output logic    fe_wr,
	output logic    p7ffd_wr,
	output logic    eff7_wr,
	output logic    bf_wr,
	output logic    sdcfg_wr,
	output logic    sddat_go,
	output logic    ay_pre_bc1,
	output logic    ay_pre_bdir,
	output rd_sel_t rd_sel
);

	logic [7:0] loa; // low address byte
	logic       ay_ext; // #FFFD, data comes from the AY

	assign loa = a[7:0];
	assign ay_ext = (loa == `ZP_FD) && (a[15:14] == 2'b11);

	//////////////////////
	// port hit and bus drive
	always_comb
	begin
		case (loa)
			`ZP_FE, `ZP_FD, `ZP_DF, `ZP_57, `ZP_BF: porthit = 1'b1;
			`ZP_1F, `ZP_F7, `ZP_77:                 porthit = ~shadow; // hidden in dos
			default:                                porthit = 1'b0;
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n & ~ay_ext;

	//////////////////////
	// write enables
	assign fe_wr    = port_wr & (loa == `ZP_FE);
	assign p7ffd_wr = port_wr & (loa == `ZP_FD) & ~a[15];
	assign eff7_wr  = port_wr & (loa == `ZP_F7) & ~shadow & ~a[12];
	assign bf_wr    = port_wr & (loa == `ZP_BF);

	// #57 doubles as config in dos when a15 set
	assign sdcfg_wr = port_wr & (((loa == `ZP_77) & ~shadow) |
	                             ((loa == `ZP_57) & shadow & a[15]));
	assign sddat_go = (loa == `ZP_57) & (port_rd | (port_wr & (~shadow | ~a[15])));

	// AY select, #FFFD address latch, #BFFD data write
	always_comb
	begin
		ay_pre_bc1  = 1'b0;
		ay_pre_bdir = 1'b0;
		if (loa == `ZP_FD)
		begin
			if (a[15:14] == 2'b11)
			begin
				ay_pre_bc1  = 1'b1;
				ay_pre_bdir = 1'b1;
			end
			else if (a[15:14] == 2'b10)
				ay_pre_bdir = 1'b1;
		end
	end

	// read source by low address only, dataout qualifies it
	always_comb
	begin
		case (loa)
			`ZP_FE:  rd_sel = RS_KEYS;
			`ZP_1F:  rd_sel = RS_JOY;
			`ZP_DF:  rd_sel = RS_MOUSE;
			`ZP_77:  rd_sel = RS_SDCFG;
			`ZP_57:  rd_sel = RS_SDDAT;
			default: rd_sel = RS_IDLE;
		endcase
	end

endmodule

//--- read_mux.sv
/* combinational, the byte is only driven when dataout is high
   sd config always reads as card present and writable */
`timescale 1ns/1ps
`include "zports_params.svh"

module read_mux
	import zports_pkg::*;
(
	input  rd_sel_t    rd_sel,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  zbyte_t     mus_in,
	input  zbyte_t     sd_dataout,
	output zbyte_t     dout
);

	always_comb
	begin
		case (rd_sel)
			RS_KEYS:  dout = {1'b1, tape_read, 1'b0, keys_in}; // ula layout
			RS_JOY:   dout = {3'b000, kj_in};
			RS_MOUSE: dout = mus_in;
			RS_SDCFG: dout = 8'h00;
			RS_SDDAT: dout = sd_dataout; // last spi byte
			default:  dout = `ZP_IDLE_BYTE;
		endcase
	end

endmodule

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_zports -o tb_zports_sim
./obj_dir/tb_zports_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

//--- tb_zports_model.svh
/* reference model of the port rules, included inside tb_zports after its signals
   state moves once per finished write access, reads touch no state */
`ifndef TB_ZPORTS_MODEL_SVH
`define TB_ZPORTS_MODEL_SVH

logic [7:0] m_p7ffd;  // raw #7FFD before the block masking
logic [7:0] m_peff7;  // raw #EFF7
logic       m_bf0;    // #BF shadow enable
logic       m_bf1;    // #BF rom write enable
logic [2:0] m_border;
logic       m_beep;
logic       m_sdcs_n;

// ports that vanish while shadow is on
function automatic logic exp_porthit(input logic [7:0] lo, input logic shd);
	if (lo == `ZP_1F || lo == `ZP_F7 || lo == `ZP_77)
		return ~shd;
	return lo == `ZP_FE || lo == `ZP_FD || lo == `ZP_DF || lo == `ZP_57 || lo == `ZP_BF;
endfunction

function automatic logic [7:0] exp_dout(input logic [7:0] lo);
	case (lo)
		`ZP_FE:  return {1'b1, tape_read, 1'b0, keys_in}; // bit 5 always low
		`ZP_1F:  return {3'b000, kj_in};
		`ZP_DF:  return mus_in;
		`ZP_77:  return 8'h00; // card present and not protected
		`ZP_57:  return sd_dataout;
		default: return `ZP_IDLE_BYTE;
	endcase
endfunction

// a config write in dos with a15 set starts no sd transfer
function automatic logic exp_sd_go(input logic [15:0] adr, input logic wr, input logic shd);
	return adr[7:0] == `ZP_57 && (!wr || !shd || !adr[15]);
endfunction

task automatic model_write(input logic [15:0] adr, input logic [7:0] d, input logic shd);
	if (adr[7:0] == `ZP_FE)
	begin
		m_border = d[2:0];
		m_beep   = d[4] ^ d[3];
	end
	if (adr[7:0] == `ZP_FD && !adr[15] && !(m_p7ffd[5] && m_peff7[2]))
		m_p7ffd = d; // skipped while locked
	if (adr[7:0] == `ZP_F7 && !shd && !adr[12])
		m_peff7 = d;
	if (adr[7:0] == `ZP_BF)
	begin
		m_bf0 = d[0];
		m_bf1 = d[1];
	end
	if ((adr[7:0] == `ZP_77 && !shd) || (adr[7:0] == `ZP_57 && shd && adr[15]))
		m_sdcs_n = d[1];
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
	if (got !== want)
	begin
		$display("error: time %0t, signal %s, got %0h, expected %0h", $time, name, got, want);
		report_failure();
	end
endtask

`endif

//--- tb_zports.sv
/* random port accesses against the model, seed fixed, 600 accesses
   each access is held 3 cycles then idle 1, stops at the first mismatch */
`timescale 1ns/1ps
`include "zports_params.svh"

module tb_zports;

	logic        zclk, rst_n, iorq_n, rd_n, wr_n, tape_read, dos, rst_rom;
	logic [15:0] a;
	logic [7:0]  din, mus_in, sd_dataout;
	logic [4:0]  keys_in, kj_in;
	logic [7:0]  dout, sd_datain, p7ffd, peff7;
	logic        dataout, porthit, beep, sdcs_n, sd_start, ay_bc1, ay_bdir;
	logic        romrw_en, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [2:0]  border;
	logic [5:0]  pent1m_page;
	integer      seed;
	int          sd_pulses = 0;   // sd_start pulses seen
	int          sd_expected = 0; // sd data accesses issued
	logic [7:0]  port_codes [0:8] = '{`ZP_FE, `ZP_FD, `ZP_F7, `ZP_1F, `ZP_DF,
	                                  `ZP_77, `ZP_57, `ZP_BF, 8'h7F};

	`include "tb_zports_model.svh"

	zports u_dut (.*);

	initial
	begin
		zclk = 1'b0;
		forever #5 zclk = ~zclk;
	end

	always @(negedge zclk)
		if (sd_start)
			sd_pulses++; // sd_start only moves on posedge

	task report_failure;
		$display("Simulation failed");
		$fatal(1, "stopped at the first failure");
	endtask

	//////////////////////
	// sequencing
	task automatic wait_sd_pulses();
		int t;
		t = 0;
		while (sd_pulses < sd_expected)
		begin
			if (t == 20)
			begin
				$display("timeout: no sd_start pulse came after an sd data access");
				report_failure();
			end
			else
			begin
				@(negedge zclk);
				#1;
				t++;
			end
		end
		check("sd_start pulses", 32'(sd_pulses), 32'(sd_expected)); // never more than one each
	endtask

	task automatic apply_reset(input logic rom);
		@(negedge zclk);
		rst_rom = rom;
		rst_n   = 1'b0;
		a       = 16'h001F; // joystick port is visible only with shadow off
		dos     = 1'b0;
		m_p7ffd = {3'b000, rom, 4'b0000};
		m_peff7 = 8'h00;
		m_bf0   = 1'b0;
		m_bf1   = 1'b0;
		m_border = 3'd0;
		m_beep   = 1'b0;
		m_sdcs_n = 1'b1;
		repeat (5) @(negedge zclk);
		rst_n = 1'b1;
		#1;
		check("sdcs_n", 32'(sdcs_n), 32'(1'b1));
		check("sd_start", 32'(sd_start), 32'(1'b0));
		check("beep", 32'(beep), 32'(1'b0));
		check("border", 32'(border), 32'(3'd0));
		check("p7ffd", 32'(p7ffd), 32'({3'b000, rom, 4'b0000})); // rom bit from rst_rom
		check("pent1m_rom", 32'(pent1m_rom), 32'(rom));
		check("peff7", 32'(peff7), 32'(8'h00));
		check("romrw_en", 32'(romrw_en), 32'(1'b0));
		check("porthit", 32'(porthit), 32'(1'b1)); // shadow_en cleared
	endtask

	task automatic check_regs();
		logic blk;
		blk = m_peff7[2]; // 1M block hides the high bits
		check("border", 32'(border), 32'(m_border));
		check("beep", 32'(beep), 32'(m_beep));
		check("sdcs_n", 32'(sdcs_n), 32'(m_sdcs_n));
		check("romrw_en", 32'(romrw_en), 32'(m_bf1));
		check("p7ffd", 32'(p7ffd), 32'(blk ? {3'b000, m_p7ffd[4:0]} : m_p7ffd));
		check("peff7", 32'(peff7), 32'(blk ? (m_peff7 & 8'hB1) : m_peff7)); // 6,3,2,1 cleared
		check("pent1m_page", 32'(pent1m_page), 32'({m_p7ffd[7:5], m_p7ffd[2:0]}));
		check("pent1m_rom", 32'(pent1m_rom), 32'(m_p7ffd[4]));
		check("pent1m_1m_on", 32'(pent1m_1m_on), 32'(!m_peff7[2]));
		check("pent1m_ram0_0", 32'(pent1m_ram0_0), 32'(m_peff7[3]));
		check("sd_datain", 32'(sd_datain), 32'(`ZP_IDLE_BYTE)); // bus idle
		check("ay_bc1", 32'(ay_bc1), 32'(1'b0));
		check("ay_bdir", 32'(ay_bdir), 32'(1'b0));
		check("dataout", 32'(dataout), 32'(1'b0));
	endtask

	task automatic run_access(input logic is_wr, input logic [15:0] adr, input logic [7:0] d);
		logic        shd;
		logic        ay_rd; // #FFFD, the AY drives the bus
		logic [31:0] r;
		@(negedge zclk);
		r = $random(seed);
		keys_in    = r[4:0];
		kj_in      = r[9:5];
		tape_read  = r[10];
		dos        = r[11];
		mus_in     = r[19:12];
		sd_dataout = r[27:20];
		shd    = dos | m_bf0;
		ay_rd  = adr[7:0] == `ZP_FD && adr[15:14] == 2'b11;
		a      = adr;
		din    = d;
		iorq_n = 1'b0;
		rd_n   = is_wr;
		wr_n   = ~is_wr;
		if (exp_sd_go(adr, is_wr, shd))
			sd_expected++;
		#1;
		// bus side has no latency
		check("porthit", 32'(porthit), 32'(exp_porthit(adr[7:0], shd)));
		check("dataout", 32'(dataout), 32'(exp_porthit(adr[7:0], shd) && !is_wr && !ay_rd));
		if (!is_wr)
			check("dout", 32'(dout), 32'(exp_dout(adr[7:0])));
		check("ay_bc1", 32'(ay_bc1), 32'(ay_rd));
		check("ay_bdir", 32'(ay_bdir), 32'(adr[7:0] == `ZP_FD && adr[15] && is_wr));
		check("sd_datain", 32'(sd_datain), 32'(is_wr ? d : `ZP_IDLE_BYTE));
		repeat (3) @(negedge zclk);
		iorq_n = 1'b1; // idle cycle
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		if (is_wr)
			model_write(adr, d, shd);
		@(negedge zclk);
		#1;
		check_regs();
		wait_sd_pulses();
	endtask

	//////////////////////
	// main sequence
	initial
	begin
		int          i;
		logic [31:0] r;
		logic [7:0]  lo;
		seed       = 32'hf47d_dbaa;
		rst_n      = 1'b0;
		rst_rom    = 1'b0;
		a          = 16'h0000;
		din        = 8'h00;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		keys_in    = 5'd0;
		tape_read  = 1'b0;
		kj_in      = 5'd0;
		mus_in     = 8'h00;
		sd_dataout = 8'h00;
		dos        = 1'b0;
		apply_reset(1'b0);
		apply_reset(1'b1); // rom bit must follow
		for (i = 0; i < 600; i++)
		begin
			r  = $random(seed);
			lo = (r[3:0] < 4'd9) ? port_codes[r[3:0]] : r[15:8]; // mostly real ports
			run_access(r[4], {r[31:24], lo}, r[23:16]);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- ula_sd_regs.sv
/* sd_start is one zclk wide, the SPI side must run on zclk
   ay and sd data outputs follow the bus with no register */
`timescale 1ns/1ps
`include "zports_params.svh"

module ula_sd_regs
	import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  zbyte_t     din,
	input  logic       fe_wr,
	input  logic       sdcfg_wr,
	input  logic       sddat_go,
	input  logic       ay_pre_bc1,
	input  logic       ay_pre_bdir,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	output logic [2:0] border,
	output logic       beep,
	output logic       sdcs_n,
	output logic       sd_start,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output zbyte_t     sd_datain
);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border   <= `ZP_BORDER_RST;
			beep     <= 1'b0;
			sdcs_n   <= `ZP_SDCS_RST;
			sd_start <= 1'b0;
		end
		else
		begin
			if (fe_wr)
			begin
				border <= din[2:0];
				beep   <= din[4] ^ din[3]; // speaker and tape out share one pin
			end
			if (sdcfg_wr)
				sdcs_n <= din[1];
			sd_start <= sddat_go; // one pulse per access
		end
	end

	assign sd_datain = wr_n ? `ZP_IDLE_BYTE : din; // reads shift out #FF

	assign ay_bc1  = ay_pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = ay_pre_bdir & ~iorq_n & ~wr_n;

endmodule

//--- zports.sv
/* z80 i/o port block, single clock zclk
   port accesses must last at least two zclk cycles, no wait states */
`timescale 1ns/1ps

module zports
	import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  zaddr_t     a,
	input  zbyte_t     din,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	output zbyte_t     dout,
	output logic       dataout,
	output logic       porthit,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  zbyte_t     mus_in,
	input  zbyte_t     sd_dataout,
	input  logic       dos,
	input  logic       rst_rom,
	output logic [2:0] border,
	output logic       beep,
	output logic       sdcs_n,
	output logic       sd_start,
	output zbyte_t     sd_datain,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output zbyte_t     p7ffd,
	output zbyte_t     peff7,
	output logic       romrw_en,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0,
	output logic [5:0] pent1m_page
);

	logic    port_wr, port_rd; // one-cycle strobes
	logic    shadow;
	logic    fe_wr, p7ffd_wr, eff7_wr, bf_wr;
	logic    sdcfg_wr, sddat_go;
	logic    ay_pre_bc1, ay_pre_bdir;
	rd_sel_t rd_sel;

	io_strobe u_strobe
	(
		.zclk(zclk), .rst_n(rst_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.port_wr(port_wr), .port_rd(port_rd)
	);

	port_decode u_decode
	(
		.a(a), .port_wr(port_wr), .port_rd(port_rd),
		.iorq_n(iorq_n), .rd_n(rd_n), .shadow(shadow),
		.porthit(porthit), .dataout(dataout),
		.fe_wr(fe_wr), .p7ffd_wr(p7ffd_wr), .eff7_wr(eff7_wr), .bf_wr(bf_wr),
		.sdcfg_wr(sdcfg_wr), .sddat_go(sddat_go),
		.ay_pre_bc1(ay_pre_bc1), .ay_pre_bdir(ay_pre_bdir), .rd_sel(rd_sel)
	);

	paging_regs u_paging
	(
		.zclk(zclk), .rst_n(rst_n), .din(din),
		.p7ffd_wr(p7ffd_wr), .eff7_wr(eff7_wr), .bf_wr(bf_wr),
		.dos(dos), .rst_rom(rst_rom),
		.shadow(shadow), .romrw_en(romrw_en), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0),
		.p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page)
	);

	ula_sd_regs u_ula_sd
	(
		.zclk(zclk), .rst_n(rst_n), .din(din),
		.fe_wr(fe_wr), .sdcfg_wr(sdcfg_wr), .sddat_go(sddat_go),
		.ay_pre_bc1(ay_pre_bc1), .ay_pre_bdir(ay_pre_bdir),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.border(border), .beep(beep), .sdcs_n(sdcs_n), .sd_start(sd_start),
		.ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .sd_datain(sd_datain)
	);

	read_mux u_rdmux
	(
		.rd_sel(rd_sel), .keys_in(keys_in), .tape_read(tape_read),
		.kj_in(kj_in), .mus_in(mus_in), .sd_dataout(sd_dataout), .dout(dout)
	);

endmodule

//--- zports_params.svh
/* port codes are the low address byte only, high byte decoded per port
   reset values apply on the asynchronous rst_n */
`ifndef ZPORTS_PARAMS_SVH
`define ZPORTS_PARAMS_SVH

// low-address port codes
`define ZP_FE 8'hFE // keyboard, tape, border, beeper
`define ZP_FD 8'hFD // #7FFD paging, #FFFD/#BFFD AY
`define ZP_F7 8'hF7 // #EFF7 paging
`define ZP_1F 8'h1F // kempston joystick
`define ZP_DF 8'hDF // kempston mouse
`define ZP_77 8'h77 // sd config
`define ZP_57 8'h57 // sd data
`define ZP_BF 8'hBF // shadow and rom write config

// bus widths
`define ZP_DW 8
`define ZP_AW 16

`define ZP_IDLE_BYTE 8'hFF // floating bus

// reset values
`define ZP_P7FFD_RST 8'h00 // bit 4 overridden by rst_rom
`define ZP_PEFF7_RST 8'h00
`define ZP_BORDER_RST 3'd0
`define ZP_SDCS_RST 1'b1 // card deselected

`endif

//--- zports_pkg.sv
/* common types of the I/O port block
   rd_sel_t is produced by the decoder and consumed by the read mux */
`include "zports_params.svh"

package zports_pkg;

	typedef logic [`ZP_AW-1:0] zaddr_t; // full z80 address
	typedef logic [`ZP_DW-1:0] zbyte_t; // one data byte

	// source of the byte driven on an IN
	typedef enum logic [2:0]
	{
		RS_IDLE  = 3'd0, // #FF
		RS_KEYS  = 3'd1, // #FE
		RS_JOY   = 3'd2, // #1F
		RS_MOUSE = 3'd3, // #DF
		RS_SDCFG = 3'd4, // #77
		RS_SDDAT = 3'd5  // #57
	} rd_sel_t;

endpackage
